//--- design/jobRegs.sv
`default_nettype none

module jobRegs (
    input  wire                 clock,
    input  wire                 rst,
    input  wire                 byteValid,
    input  wire [7:0]           byteData,
    output minerPkg::jobFields  job,
    output logic                jobStart
);
    import minerPkg::*;

    jobFrame    frame;
    jobFrame    nextFrame;
    logic [3:0] byteCount;
    logic       lastByte;

    assign lastByte = (byteCount == 4'(jobBytes - 1));

    // Incoming byte merged at its index
    always_comb begin
        nextFrame = frame;
        nextFrame.bytes[byteCount] = byteData;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            byteCount <= '0;
            jobStart  <= 1'b0;
        end else begin
            jobStart <= 1'b0;
            if (byteValid) begin
                if (lastByte) begin
                    byteCount <= '0;
                    jobStart  <= 1'b1;
                end else begin
                    byteCount <= byteCount + 4'd1;
                end
            end
        end
    end

    // Job held stable for the search until the next full frame
    always_ff @(posedge clock) begin
        if (byteValid) begin
            frame <= nextFrame;
            if (lastByte) begin
                job <= nextFrame.fields;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/minerPkg.sv
`default_nettype none

package minerPkg;

    // Serial line timing
    localparam int clocksPerBit = 8;
    localparam int bitTimerW = $clog2(clocksPerBit);
    // Four bytes, each with start and stop bit
    localparam int txFrameBits = 40;
    localparam int txCountW = $clog2(txFrameBits + 1);

    // Job frame and hash
    localparam int jobBytes = 13;
    localparam int hashCycles = 66;
    // Message is 12 data bytes plus the nonce
    localparam logic [63:0] msgBits = 64'd128;

    localparam logic [0:63][31:0] roundK = {
        32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
        32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
        32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
        32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
        32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
        32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
        32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
        32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
        32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
        32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
        32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
        32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
        32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
        32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
        32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
        32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
    };

    // Working variables a to h
    typedef struct packed {
        logic [31:0] a, b, c, d, e, f, g, h;
    } hashState;

    localparam hashState hashInit = {
        32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
        32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
    };

    typedef struct packed {
        logic [95:0] blockData;
        // Leading zero bits wanted, 0 to 32
        logic [7:0]  difficulty;
    } jobFields;

    // Byte 0 is the first byte on the line and the top of blockData
    typedef union packed {
        logic [0:jobBytes-1][7:0] bytes;
        jobFields                 fields;
    } jobFrame;

endpackage

`default_nettype wire

//--- design/minerTop.sv
`default_nettype none

module minerTop (
    input  wire clock,
    input  wire rst,
    input  wire rxd,
    output wire txd,
    output wire mining,
    output wire found
);
    import minerPkg::*;

    logic         byteValid;
    logic [7:0]   byteData;
    jobFields     job;
    logic         jobStart;
    logic         hashStart;
    logic [511:0] block;
    logic         hashDone;
    logic [255:0] digest;
    logic         sendStart;
    logic [31:0]  winNonce;
    // Only watched from outside the datapath
    logic         busy;

    uartReceiver uartReceiver_inst (
        .clock(clock), .rst(rst), .rxd(rxd),
        .byteValid(byteValid), .byteData(byteData)
    );

    // Job config sits beside the search it steers
    jobRegs jobRegs_inst (
        .clock(clock), .rst(rst), .byteValid(byteValid), .byteData(byteData),
        .job(job), .jobStart(jobStart)
    );

    nonceSearch nonceSearch_inst (
        .clock(clock), .rst(rst), .job(job), .jobStart(jobStart),
        .hashDone(hashDone), .digest(digest), .hashStart(hashStart),
        .block(block), .mining(mining), .found(found),
        .sendStart(sendStart), .winNonce(winNonce)
    );

    sha256Core sha256Core_inst (
        .clock(clock), .rst(rst), .hashStart(hashStart), .block(block),
        .hashDone(hashDone), .digest(digest)
    );

    uartTransmitter uartTransmitter_inst (
        .clock(clock), .rst(rst), .sendStart(sendStart), .winNonce(winNonce),
        .txd(txd), .busy(busy)
    );

endmodule

`default_nettype wire

//--- design/nonceSearch.sv
`default_nettype none

module nonceSearch (
    input  wire                 clock,
    input  wire                 rst,
    input  wire minerPkg::jobFields job,
    input  wire                 jobStart,
    input  wire                 hashDone,
    input  wire  [255:0]        digest,
    output logic                hashStart,
    output logic [511:0]        block,
    output logic                mining,
    output logic                found,
    output logic                sendStart,
    output logic [31:0]         winNonce
);
    import minerPkg::*;

    logic [31:0] nonce;
    logic [31:0] zeroMask;
    logic        hit;
    logic        doneSeen;

    // Data, nonce, pad bit, zeros, then the 64-bit length
    assign block = {job.blockData, nonce, 1'b1, 319'd0, msgBits};

    // Top difficulty bits of H0 must be clear
    assign zeroMask = ~(32'hffff_ffff >> job.difficulty);
    assign hit = (digest[255:224] & zeroMask) == 32'd0;

    // Done during a restart is from the abandoned hash
    assign doneSeen = hashDone && mining && !hashStart;

    always_ff @(posedge clock) begin
        if (rst) begin
            nonce     <= '0;
            mining    <= 1'b0;
            found     <= 1'b0;
            hashStart <= 1'b0;
            sendStart <= 1'b0;
        end else begin
            hashStart <= 1'b0;
            sendStart <= 1'b0;
            if (jobStart) begin
                nonce     <= '0;
                mining    <= 1'b1;
                found     <= 1'b0;
                hashStart <= 1'b1;
            end else if (doneSeen) begin
                if (hit) begin
                    found     <= 1'b1;
                    mining    <= 1'b0;
                    sendStart <= 1'b1;
                end else if (&nonce) begin
                    // Nonce space exhausted
                    mining <= 1'b0;
                end else begin
                    nonce     <= nonce + 32'd1;
                    hashStart <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!jobStart && doneSeen && hit) begin
            winNonce <= nonce;
        end
    end

endmodule

`default_nettype wire

//--- design/sha256Core.sv
`default_nettype none

module sha256Core (
    input  wire          clock,
    input  wire          rst,
    input  wire          hashStart,
    input  wire  [511:0] block,
    output logic         hashDone,
    output logic [255:0] digest
);
    import minerPkg::*;

    hashState          state;
    // sched[0] is the W word of the current round
    logic [0:15][31:0] sched;
    logic              running;
    // 1 to 64 are rounds, 65 is the final add
    logic [6:0]        step;
    logic [5:0]        roundIdx;
    logic              lastStep;
    logic              roundStep;
    logic [31:0]       t1;
    logic [31:0]       t2;
    logic [31:0]       nextW;

    function automatic logic [31:0] rotr(input logic [31:0] x, input int n);
        return (x >> n) | (x << (32 - n));
    endfunction

    assign roundIdx  = step[5:0] - 6'd1;
    assign lastStep  = running && (step == 7'(hashCycles - 1));
    assign roundStep = running && !lastStep;

    always_comb begin
        t1 = state.h + (rotr(state.e, 6) ^ rotr(state.e, 11) ^ rotr(state.e, 25))
           + ((state.e & state.f) ^ (~state.e & state.g))
           + roundK[roundIdx] + sched[0];
        t2 = (rotr(state.a, 2) ^ rotr(state.a, 13) ^ rotr(state.a, 22))
           + ((state.a & state.b) ^ (state.a & state.c) ^ (state.b & state.c));
        // Schedule word sixteen rounds ahead
        nextW = (rotr(sched[14], 17) ^ rotr(sched[14], 19) ^ (sched[14] >> 10))
              + sched[9]
              + (rotr(sched[1], 7) ^ rotr(sched[1], 18) ^ (sched[1] >> 3))
              + sched[0];
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            running  <= 1'b0;
            step     <= '0;
            hashDone <= 1'b0;
        end else begin
            hashDone <= 1'b0;
            // A new start drops any hash in flight
            if (hashStart) begin
                running <= 1'b1;
                step    <= 7'd1;
            end else if (running) begin
                step <= step + 7'd1;
                if (lastStep) begin
                    running  <= 1'b0;
                    hashDone <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (hashStart) begin
            state <= hashInit;
            sched <= block;
        end else if (roundStep) begin
            state <= {t1 + t2, state.a, state.b, state.c,
                      state.d + t1, state.e, state.f, state.g};
            sched <= {sched[1:15], nextW};
        end
    end

    // Digest holds until the next final add
    always_ff @(posedge clock) begin
        if (!hashStart && lastStep) begin
            digest <= {state.a + hashInit.a, state.b + hashInit.b,
                       state.c + hashInit.c, state.d + hashInit.d,
                       state.e + hashInit.e, state.f + hashInit.f,
                       state.g + hashInit.g, state.h + hashInit.h};
        end
    end

endmodule

`default_nettype wire

//--- design/uartReceiver.sv
`default_nettype none

module uartReceiver (
    input  wire        clock,
    input  wire        rst,
    input  wire        rxd,
    output logic       byteValid,
    output logic [7:0] byteData
);
    import minerPkg::*;

    logic                 rxMeta;
    logic                 rxSync;
    logic                 rxPrev;
    logic                 receiving;
    logic [bitTimerW-1:0] bitTimer;
    // 0 start, 1 to 8 data, 9 stop
    logic [3:0]           bitIdx;
    logic                 sampleNow;

    assign sampleNow = receiving && (bitTimer == '0);

    // Two flop synchronizer, plus one more for edge detect
    always_ff @(posedge clock) begin
        if (rst) begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
            rxPrev <= 1'b1;
        end else begin
            rxMeta <= rxd;
            rxSync <= rxMeta;
            rxPrev <= rxSync;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            receiving <= 1'b0;
            bitTimer  <= '0;
            bitIdx    <= '0;
            byteValid <= 1'b0;
        end else begin
            byteValid <= 1'b0;
            if (!receiving) begin
                // Falling edge starts a frame, first sample half a bit later
                if (rxPrev && !rxSync) begin
                    receiving <= 1'b1;
                    bitTimer  <= bitTimerW'(clocksPerBit / 2 - 1);
                    bitIdx    <= '0;
                end
            end else if (!sampleNow) begin
                bitTimer <= bitTimer - 1'b1;
            end else begin
                bitTimer <= bitTimerW'(clocksPerBit - 1);
                bitIdx   <= bitIdx + 4'd1;
                // Start bit gone high again, just a glitch
                if (bitIdx == 4'd0 && rxSync) begin
                    receiving <= 1'b0;
                end else if (bitIdx == 4'd9) begin
                    receiving <= 1'b0;
                    // Bad stop bit drops the byte
                    byteValid <= rxSync;
                end
            end
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clock) begin
        if (sampleNow && bitIdx >= 4'd1 && bitIdx <= 4'd8) begin
            byteData <= {rxSync, byteData[7:1]};
        end
    end

endmodule

`default_nettype wire

//--- design/uartTransmitter.sv
`default_nettype none

module uartTransmitter (
    input  wire        clock,
    input  wire        rst,
    input  wire        sendStart,
    input  wire [31:0] winNonce,
    output wire        txd,
    output logic       busy
);
    import minerPkg::*;

    logic [txFrameBits-1:0] frame;
    logic [bitTimerW-1:0]   bitTimer;
    logic [txCountW-1:0]    bitsLeft;
    logic                   bitEnd;
    logic                   loadFrame;

    assign bitEnd = busy && (bitTimer == bitTimerW'(clocksPerBit - 1));
    // Ignored while a frame is going out
    assign loadFrame = sendStart && !busy;
    // Line idles high
    assign txd = busy ? frame[0] : 1'b1;

    always_ff @(posedge clock) begin
        if (rst) begin
            busy     <= 1'b0;
            bitTimer <= '0;
            bitsLeft <= '0;
        end else if (loadFrame) begin
            busy     <= 1'b1;
            bitTimer <= '0;
            bitsLeft <= txCountW'(txFrameBits);
        end else if (bitEnd) begin
            bitTimer <= '0;
            bitsLeft <= bitsLeft - 1'b1;
            // Last stop bit done
            if (bitsLeft == txCountW'(1)) begin
                busy <= 1'b0;
            end
        end else if (busy) begin
            bitTimer <= bitTimer + 1'b1;
        end
    end

    // Per byte: start, 8 data LSB first, stop; byte 0 goes first
    always_ff @(posedge clock) begin
        if (loadFrame) begin
            frame <= {1'b1, winNonce[31:24], 1'b0, 1'b1, winNonce[23:16], 1'b0,
                      1'b1, winNonce[15:8], 1'b0, 1'b1, winNonce[7:0], 1'b0};
        end else if (bitEnd) begin
            frame <= {1'b1, frame[txFrameBits-1:1]};
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module minerTb -o minerSim
./obj_dir/minerSim > sim.log 2>&1 || true
cat sim.log
if grep -q "Done: errors found" sim.log; then
    exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
    echo "Simulation stopped before the testbench reported a result"
    exit 1
fi

//--- test/shaModel.svh
`ifndef SHA_MODEL_SVH
`define SHA_MODEL_SVH

// LFSR state, 32-bit Fibonacci with taps 32 22 2 1
logic [31:0] lfsrState = 32'h103c_92fd;

// One LFSR step per bit taken
function automatic logic [31:0] randomBits(input int count);
    logic [31:0] value;
    logic        feedback;
    value = '0;
    for (int i = 0; i < count; i++) begin
        feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], feedback};
        value = {value[30:0], feedback};
    end
    return value;
endfunction

function automatic logic [31:0] rotRight(input logic [31:0] x, input int n);
    logic [63:0] doubled;
    doubled = {x, x} >> n;
    return doubled[31:0];
endfunction

// 16 message bytes: 12 data bytes, then the nonce big endian
function automatic logic [511:0] paddedBlock(input logic [95:0] data,
                                             input logic [31:0] nonce);
    logic [511:0] blk;
    blk = '0;
    blk[511:416] = data;
    blk[415:384] = nonce;
    // Terminating one bit right after the message
    blk[383:376] = 8'h80;
    // Message length in bits
    blk[63:0] = 64'd128;
    return blk;
endfunction

// Plain 64-entry schedule, one compression from the initial state
function automatic logic [255:0] modelHash(input logic [511:0] blk);
    logic [31:0]  w [64];
    logic [31:0]  v [8];
    logic [255:0] init;
    logic [255:0] result;
    logic [31:0]  sig0;
    logic [31:0]  sig1;
    logic [31:0]  sum0;
    logic [31:0]  sum1;
    logic [31:0]  ch;
    logic [31:0]  maj;
    logic [31:0]  tmp1;
    logic [31:0]  tmp2;
    init = minerPkg::hashInit;
    for (int i = 0; i < 16; i++) begin
        w[i] = blk[511 - 32 * i -: 32];
    end
    for (int i = 16; i < 64; i++) begin
        sig0 = rotRight(w[i-15], 7) ^ rotRight(w[i-15], 18) ^ (w[i-15] >> 3);
        sig1 = rotRight(w[i-2], 17) ^ rotRight(w[i-2], 19) ^ (w[i-2] >> 10);
        w[i] = w[i-16] + sig0 + w[i-7] + sig1;
    end
    for (int i = 0; i < 8; i++) begin
        v[i] = init[255 - 32 * i -: 32];
    end
    for (int i = 0; i < 64; i++) begin
        sum1 = rotRight(v[4], 6) ^ rotRight(v[4], 11) ^ rotRight(v[4], 25);
        ch   = (v[4] & v[5]) ^ (~v[4] & v[6]);
        tmp1 = v[7] + sum1 + ch + minerPkg::roundK[i] + w[i];
        sum0 = rotRight(v[0], 2) ^ rotRight(v[0], 13) ^ rotRight(v[0], 22);
        maj  = (v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]);
        tmp2 = sum0 + maj;
        for (int j = 7; j > 0; j--) begin
            v[j] = v[j-1];
        end
        // v[4] now holds the old d
        v[4] = v[4] + tmp1;
        v[0] = tmp1 + tmp2;
    end
    for (int i = 0; i < 8; i++) begin
        result[255 - 32 * i -: 32] = v[i] + init[255 - 32 * i -: 32];
    end
    return result;
endfunction

function automatic int leadingZeros(input logic [255:0] h);
    int count;
    count = 0;
    while (count < 256 && !h[255 - count]) begin
        count++;
    end
    return count;
endfunction

// Lowest nonce meeting the difficulty, or -1 within the limit
function automatic longint firstSolution(input logic [95:0] data, input int difficulty,
                                         input int limit);
    for (int n = 0; n < limit; n++) begin
        if (leadingZeros(modelHash(paddedBlock(data, 32'(n)))) >= difficulty) begin
            return n;
        end
    end
    return -1;
endfunction

`endif

//--- test/minerTb.sv
`default_nettype none

module minerTb;
    import minerPkg::*;

    `include "shaModel.svh"

    localparam int idleCycles = 20;
    // Model search bound, far above any expected solution
    localparam int modelLimit = 1 << 16;

    logic clock;
    logic rst;
    logic rxd;
    wire  txd;
    wire  mining;
    wire  found;

    int errorCount;
    int testsRun;
    int testsFailed;
    bit timedOut;

    minerTop minerTop_inst (
        .clock(clock), .rst(rst), .rxd(rxd),
        .txd(txd), .mining(mining), .found(found)
    );

    bind minerTop minerTop_checker minerTop_checker_inst (
        .clock(clock), .rst(rst), .txd(txd), .busy(busy),
        .mining(mining), .found(found)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #2 clock = ~clock;
        end
    end

    // Everything happens 1 unit after the rising edge
    task automatic nextCycle();
        @(posedge clock);
        #1;
    endtask

    task automatic waitCycles(input int count);
        for (int i = 0; i < count; i++) begin
            nextCycle();
        end
    endtask

    task automatic expectTrue(input bit ok, input string msg);
        assert (ok) else begin
            errorCount++;
            $display("CHECK FAILED at time %0t: %s", $time, msg);
        end
    endtask

    // Start, 8 data bits LSB first, stop
    task automatic sendByte(input logic [7:0] value);
        logic [9:0] bits;
        bits = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rxd = bits[i];
            waitCycles(clocksPerBit);
        end
    endtask

    // Data bytes from the top down, difficulty last
    task automatic sendJob(input logic [95:0] data, input logic [7:0] difficulty);
        for (int i = 11; i >= 0; i--) begin
            sendByte(data[8 * i +: 8]);
        end
        sendByte(difficulty);
        // Let the last byte reach the search
        waitCycles(2 * clocksPerBit);
    endtask

    task automatic waitFound(input int limit);
        int count;
        count = 0;
        while (!timedOut && !found) begin
            if (count >= limit) begin
                timedOut = 1'b1;
                $display("Timeout: found did not rise within %0d cycles", limit);
            end else begin
                nextCycle();
                count++;
            end
        end
    endtask

    task automatic waitMining(input int limit);
        int count;
        count = 0;
        while (!timedOut && !mining) begin
            if (count >= limit) begin
                timedOut = 1'b1;
                $display("Timeout: mining did not rise within %0d cycles", limit);
            end else begin
                nextCycle();
                count++;
            end
        end
    endtask

    task automatic waitStartBit(input int limit);
        int count;
        count = 0;
        while (!timedOut && txd) begin
            if (count >= limit) begin
                timedOut = 1'b1;
                $display("Timeout: no start bit on txd within %0d cycles", limit);
            end else begin
                nextCycle();
                count++;
            end
        end
    endtask

    // got[0] is the first byte on the line
    task automatic captureNonce(output logic [0:3][7:0] got);
        logic [7:0] value;
        got = '0;
        for (int b = 0; b < 4; b++) begin
            waitStartBit(4 * clocksPerBit);
            if (timedOut) begin
                return;
            end
            // Middle of the start bit
            waitCycles(clocksPerBit / 2);
            expectTrue(txd == 1'b0, $sformatf("start bit of byte %0d not low", b));
            value = '0;
            for (int i = 0; i < 8; i++) begin
                waitCycles(clocksPerBit);
                value = {txd, value[7:1]};
            end
            waitCycles(clocksPerBit);
            expectTrue(txd == 1'b1, $sformatf("stop bit of byte %0d not high", b));
            got[b] = value;
        end
    endtask

    function automatic logic [95:0] randomData();
        logic [95:0] data;
        data = '0;
        for (int i = 0; i < 3; i++) begin
            data = {data[63:0], randomBits(32)};
        end
        return data;
    endfunction

    // Send one job and capture the reply
    task automatic runJob(input logic [95:0] data, input int difficulty,
                          output logic [0:3][7:0] got, output longint sol);
        longint tries;
        got = '0;
        sol = firstSolution(data, difficulty, modelLimit);
        expectTrue(sol >= 0, "model found no solution for the job");
        tries = (sol < 0) ? modelLimit : sol + 1;
        sendJob(data, 8'(difficulty));
        waitFound(int'(tries * (hashCycles + 1) + 64));
        if (!timedOut) begin
            captureNonce(got);
        end
    endtask

    task automatic testIdleAfterReset();
        for (int i = 0; i < idleCycles; i++) begin
            nextCycle();
            expectTrue(txd && !mining && !found,
                       $sformatf("idle txd %b mining %b found %b", txd, mining, found));
        end
    endtask

    task automatic testDifficultyZero();
        logic [0:3][7:0] got;
        longint          sol;
        runJob(randomData(), 0, got, sol);
        if (timedOut) begin
            return;
        end
        expectTrue(found, "found low after the reply");
        expectTrue(got == '0, $sformatf("nonce bytes %h, expected all zero", got));
    endtask

    task automatic testDifficultyEight();
        logic [95:0]     data;
        logic [0:3][7:0] got;
        logic [31:0]     nonce;
        longint          sol;
        data = randomData();
        runJob(data, 8, got, sol);
        if (timedOut) begin
            return;
        end
        nonce = {got[3], got[2], got[1], got[0]};
        expectTrue(nonce == 32'(sol), $sformatf("nonce %h, expected %h", nonce, 32'(sol)));
        expectTrue(leadingZeros(modelHash(paddedBlock(data, nonce))) >= 8,
                   $sformatf("nonce %h has fewer than 8 leading zero bits", nonce));
    endtask

    // Second job lands while the first is still searching
    task automatic testRestart();
        logic [95:0]     first;
        logic [95:0]     second;
        logic [0:3][7:0] got;
        logic [31:0]     nonce;
        longint          sol;
        first = randomData();
        second = randomData();
        sendJob(first, 8'd20);
        waitMining(4 * clocksPerBit);
        if (timedOut) begin
            return;
        end
        expectTrue(!found, "first job solved before the restart");
        // Low difficulty, so a search that kept its old nonce overshoots
        runJob(second, 1, got, sol);
        if (timedOut) begin
            return;
        end
        nonce = {got[3], got[2], got[1], got[0]};
        expectTrue(nonce == 32'(sol),
                   $sformatf("after restart nonce %h, expected %h", nonce, 32'(sol)));
    endtask

    task automatic testByteOrder();
        logic [0:3][7:0] got;
        logic [31:0]     want;
        longint          sol;
        int              lowSeen;
        runJob(randomData(), 4, got, sol);
        if (timedOut) begin
            return;
        end
        want = 32'(sol);
        for (int i = 0; i < 4; i++) begin
            expectTrue(got[i] == want[8 * i +: 8],
                       $sformatf("byte %0d is %h, expected %h", i, got[i], want[8 * i +: 8]));
        end
        // Line must stay quiet after the four bytes
        lowSeen = 0;
        for (int i = 0; i < 20 * clocksPerBit; i++) begin
            nextCycle();
            if (!txd) begin
                lowSeen++;
            end
        end
        expectTrue(lowSeen == 0, $sformatf("txd low for %0d cycles after the reply", lowSeen));
    endtask

    task automatic runTest(input int id, input string name);
        int errorsBefore;
        errorsBefore = errorCount;
        if (timedOut) begin
            return;
        end
        case (id)
            1: testIdleAfterReset();
            2: testDifficultyZero();
            3: testDifficultyEight();
            4: testRestart();
            default: testByteOrder();
        endcase
        testsRun++;
        if (timedOut || errorCount != errorsBefore) begin
            testsFailed++;
            $display("Test %0d %s: FAIL", id, name);
        end else begin
            $display("Test %0d %s: PASS", id, name);
        end
    endtask

    initial begin
        rst = 1'b1;
        rxd = 1'b1;
        errorCount = 0;
        testsRun = 0;
        testsFailed = 0;
        timedOut = 1'b0;
        repeat (10) @(posedge clock);
        #1;
        rst = 1'b0;

        runTest(1, "idle after reset");
        runTest(2, "difficulty 0 returns nonce 0");
        runTest(3, "difficulty 8 first solution");
        runTest(4, "new job restarts search");
        runTest(5, "nonce bytes LSB first");

        $display("Tests run %0d, failed %0d, check errors %0d",
                 testsRun, testsFailed, errorCount);
        if (timedOut || errorCount > 0) begin
            $display("Done: errors found");
        end else begin
            $display("Done: no errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/minerTop_checker.sv
`default_nettype none

module minerTop_checker (
    input wire clock,
    input wire rst,
    input wire txd,
    input wire busy,
    input wire mining,
    input wire found
);

    // A search runs or has a winner, never both
    foundNotMining: assert property (
        @(posedge clock) disable iff (rst) !(found && mining)
    ) else $error("found and mining are high together");

    // Serial line idles high
    idleLineHigh: assert property (
        @(posedge clock) disable iff (rst) !busy |-> txd
    ) else $error("txd low while the transmitter is idle");

    // Winner only as the search stops
    foundAfterMining: assert property (
        @(posedge clock) disable iff (rst) $rose(found) |-> $fell(mining)
    ) else $error("found rose without mining falling on the same edge");

endmodule

`default_nettype wire

//--- vlog.f
+incdir+test
design/minerPkg.sv
design/uartReceiver.sv
design/uartTransmitter.sv
design/jobRegs.sv
design/sha256Core.sv
design/nonceSearch.sv
design/minerTop.sv
test/minerTop_checker.sv
test/minerTb.sv
